// File: bench/adapter_input.txt
// op(1 write) kind(1 line) addr id data0 data1 data2 data3 strobes
// exp0 exp1 exp2 exp3 (expected rdata_o words, zero for writes)
1 0 00000100 1 11223344 00000000 00000000 00000000 0005 00000000 00000000 00000000 00000000
0 0 00000100 2 00000000 00000000 00000000 00000000 0000 c0220144 00000000 00000000 00000000
1 1 00000200 3 a0000000 a1111111 a2222222 a3333333 c03f 00000000 00000000 00000000 00000000
0 1 00000208 4 00000000 00000000 00000000 00000000 0000 a0000000 c0de1111 c0de0208 a333020c
0 1 0000030c 5 00000000 00000000 00000000 00000000 0000 c0de0300 c0de0304 c0de0308 c0de030c
1 0 00000304 6 deadbeef 00000000 00000000 00000000 000f 00000000 00000000 00000000 00000000
0 0 00000304 7 00000000 00000000 00000000 00000000 0000 deadbeef 00000000 00000000 00000000
0 1 00000300 8 00000000 00000000 00000000 00000000 0000 c0de0300 deadbeef c0de0308 c0de030c
1 1 00000400 9 00000001 00000002 00000003 00000004 ffff 00000000 00000000 00000000 00000000
0 1 00000404 a 00000000 00000000 00000000 00000000 0000 00000001 00000002 00000003 00000004

// File: tb.f
src/axi_adapter_pkg.sv
src/rsp_if.sv
src/axi_write_engine.sv
src/axi_read_engine.sv
src/rsp_arbiter.sv
src/axi_adapter.sv
bench/axi_adapter_chk.sv
bench/tb_axi_adapter.sv

// File: Makefile
SIM      ?= verilator
TOP      ?= tb_axi_adapter
FILELIST ?= tb.f
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_axi_adapter.sv
// Testbench for the cache-side AXI adapter.
// Requests and expected read lines come from bench/adapter_input.txt.
// A word-memory AXI slave with random ready delays and R gaps answers
// the DUT; responses are matched to requests by id.

`default_nettype none

module tb_axi_adapter
  import axi_adapter_pkg::*;
();

  localparam int    MAX_REQ = 16;
  localparam int    FIELDS  = 13;
  localparam word_t PATTERN = 32'hc0de0000;

  logic       clk_i, rst_ni, req_i, we_i;
  req_kind_t  kind_i;
  addr_t      addr_i;
  line_t      wdata_i;
  line_strb_t be_i;
  logic [1:0] size_i;
  id_t        id_i;
  logic       gnt_o, valid_o, critical_word_valid_o;
  line_t      rdata_o;
  id_t        id_o;
  word_t      critical_word_o;
  logic       aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, w_last_o;
  addr_t      aw_addr_o, ar_addr_o;
  logic [7:0] aw_len_o, ar_len_o;
  logic [2:0] aw_size_o, ar_size_o;
  id_t        aw_id_o, ar_id_o, b_id_i, r_id_i;
  word_t      w_data_o, r_data_i;
  strb_t      w_strb_o;
  logic       b_valid_i, b_ready_o, ar_valid_o, ar_ready_i;
  logic       r_valid_i, r_ready_o, r_last_i;

  word_t       stim [0:MAX_REQ*FIELDS-1];
  word_t       mem [0:1023];
  line_t       exp_line [0:15];
  word_t       exp_crit [0:15];
  logic        is_line_rd [0:15];
  int          rsp_cnt [0:15];
  int          crit_cnt [0:15];
  int          num_req, checks, errors, gnt_total, rsp_total;
  id_t         cur_rd_id;
  logic        loaded;
  logic [31:0] lcg_state;

  axi_adapter u_axi_adapter (.*);

  bind axi_adapter axi_adapter_chk u_chk (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .aw_valid_o (aw_valid_o), .aw_ready_i (aw_ready_i), .aw_addr_o (aw_addr_o),
    .aw_len_o (aw_len_o), .w_valid_o (w_valid_o), .w_ready_i (w_ready_i),
    .w_data_o (w_data_o), .w_last_o (w_last_o), .b_valid_i (b_valid_i),
    .b_ready_o (b_ready_o), .ar_valid_o (ar_valid_o), .ar_ready_i (ar_ready_i),
    .ar_addr_o (ar_addr_o), .r_valid_i (r_valid_i), .r_ready_o (r_ready_o),
    .r_data_i (r_data_i), .valid_o (valid_o),
    .critical_word_valid_o (critical_word_valid_o)
  );

  function automatic int rand_delay();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[31:30]);
  endfunction

  task automatic check(input string name, input logic [127:0] expv, input logic [127:0] act);
    checks++;
    if (expv !== act) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, expv, act);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // --------------------
  // AXI write slave
  // --------------------
  initial begin
    addr_t     a;
    id_t       id;
    int        n;
    logic [9:0] idx;
    aw_ready_i = 1'b0;
    w_ready_i  = 1'b0;
    b_valid_i  = 1'b0;
    b_id_i     = '0;
    forever begin
      do @(negedge clk_i); while (!aw_valid_o);
      repeat (rand_delay()) @(posedge clk_i);
      @(posedge clk_i);
      #1 aw_ready_i = 1'b1;
      @(negedge clk_i);
      a  = aw_addr_o;
      n  = int'(aw_len_o);
      id = aw_id_o;
      check("aw_size", 128'($clog2(WORD_WIDTH / 8)), 128'(aw_size_o));
      @(posedge clk_i);
      #1 aw_ready_i = 1'b0;
      // W is accepted only after AW, so beats map to a known address
      for (int b = 0; b <= n; b++) begin
        repeat (rand_delay()) @(posedge clk_i);
        @(posedge clk_i);
        #1 w_ready_i = 1'b1;
        do @(negedge clk_i); while (!w_valid_o);
        idx = a[11:2] + 10'(b);
        for (int k = 0; k < 4; k++) begin
          if (w_strb_o[k]) mem[idx][8*k +: 8] = w_data_o[8*k +: 8];
        end
        check("w_last", 128'(b == n), 128'(w_last_o));
        @(posedge clk_i);
        #1 w_ready_i = 1'b0;
      end
      repeat (rand_delay()) @(posedge clk_i);
      @(posedge clk_i);
      #1 b_valid_i = 1'b1;
      b_id_i = id;
      do @(negedge clk_i); while (!b_ready_o);
      @(posedge clk_i);
      #1 b_valid_i = 1'b0;
    end
  end

  // --------------------
  // AXI read slave
  // --------------------
  initial begin
    addr_t     a;
    id_t       id;
    int        n;
    logic [9:0] idx;
    word_t     beat_buf [0:3];
    ar_ready_i = 1'b0;
    r_valid_i  = 1'b0;
    r_data_i   = '0;
    r_id_i     = '0;
    r_last_i   = 1'b0;
    forever begin
      do @(negedge clk_i); while (!ar_valid_o);
      repeat (rand_delay()) @(posedge clk_i);
      @(posedge clk_i);
      #1 ar_ready_i = 1'b1;
      @(negedge clk_i);
      a  = ar_addr_o;
      n  = int'(ar_len_o);
      id = ar_id_o;
      check("ar_addr", 128'((kind_i == LINE_REQ) ? {addr_i[31:4], 4'h0} : addr_i), 128'(a));
      check("ar_size", 128'($clog2(WORD_WIDTH / 8)), 128'(ar_size_o));
      // read data is the memory content at the time AR is accepted
      for (int b = 0; b <= n; b++) begin
        idx = a[11:2] + 10'(b);
        beat_buf[b] = mem[idx];
      end
      @(posedge clk_i);
      #1 ar_ready_i = 1'b0;
      for (int b = 0; b <= n; b++) begin
        repeat (rand_delay()) @(posedge clk_i);
        @(posedge clk_i);
        #1 r_valid_i = 1'b1;
        r_data_i = beat_buf[b];
        r_id_i   = id;
        r_last_i = (b == n);
        do @(negedge clk_i); while (!r_ready_o);
        @(posedge clk_i);
        #1 r_valid_i = 1'b0;
        r_last_i = 1'b0;
      end
    end
  end

  // --------------------
  // response monitors
  // --------------------
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (gnt_o) gnt_total++;
      if (critical_word_valid_o) begin
        crit_cnt[cur_rd_id]++;
        check("critical_word", 128'(exp_crit[cur_rd_id]), 128'(critical_word_o));
      end
      if (valid_o) begin
        rsp_cnt[id_o]++;
        rsp_total++;
        check("rdata", exp_line[id_o], rdata_o);
        if (is_line_rd[id_o]) check("critical_count", 128'(1), 128'(crit_cnt[id_o]));
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (200 * num_req + 20) @(posedge clk_i);
    $display("watchdog expired with %0d of %0d responses", rsp_total, num_req);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int base;
    id_t rid;
    lcg_state = 32'ha750;
    checks = 0;
    errors = 0;
    gnt_total = 0;
    rsp_total = 0;
    num_req = 0;
    cur_rd_id = '0;
    loaded = 1'b0;
    rst_ni = 1'b0;
    req_i = 1'b0;
    we_i = 1'b0;
    kind_i = SINGLE_REQ;
    addr_i = '0;
    wdata_i = '0;
    be_i = '0;
    size_i = 2'd2;
    id_i = '0;
    for (int i = 0; i < 1024; i++) mem[i] = word_t'(i << 2) ^ PATTERN;
    for (int i = 0; i < MAX_REQ * FIELDS; i++) stim[i] = '1;
    for (int i = 0; i < 16; i++) begin
      rsp_cnt[i] = 0;
      crit_cnt[i] = 0;
      is_line_rd[i] = 1'b0;
    end
    $readmemh("bench/adapter_input.txt", stim);
    while (num_req < MAX_REQ && stim[num_req * FIELDS] != '1) begin
      base = num_req * FIELDS;
      for (int w = 0; w < 4; w++) exp_line[stim[base+3][3:0]][w] = stim[base+9+w];
      exp_crit[stim[base+3][3:0]] = stim[base+9+int'(stim[base+2][3:2])];
      is_line_rd[stim[base+3][3:0]] = !stim[base][0] && stim[base+1][0];
      num_req++;
    end
    loaded = 1'b1;
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    check("reset_outputs", 128'(0), 128'({gnt_o, valid_o, critical_word_valid_o,
          aw_valid_o, w_valid_o, ar_valid_o, b_ready_o, r_ready_o}));
    for (int r = 0; r < num_req; r++) begin
      base = r * FIELDS;
      @(posedge clk_i);
      #1 req_i = 1'b1;
      we_i   = stim[base][0];
      kind_i = req_kind_t'(stim[base+1][0]);
      addr_i = stim[base+2];
      id_i   = stim[base+3][3:0];
      for (int w = 0; w < 4; w++) wdata_i[w] = stim[base+4+w];
      be_i   = stim[base+8][15:0];
      do @(negedge clk_i); while (!gnt_o);
      if (!we_i) cur_rd_id = id_i;
      @(posedge clk_i);
      #1 req_i = 1'b0;
    end
    while (rsp_total < num_req) @(negedge clk_i);
    repeat (5) @(negedge clk_i);
    check("gnt_count", 128'(num_req), 128'(gnt_total));
    for (int r = 0; r < num_req; r++) begin
      rid = stim[r*FIELDS+3][3:0];
      check("valid_count", 128'(1), 128'(rsp_cnt[rid]));
      // only line reads flag a critical word, and only once
      check("critical_total", 128'(is_line_rd[rid]), 128'(crit_cnt[rid]));
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/axi_adapter_chk.sv
// Concurrent checks bound into the adapter top level: AXI valid/payload
// stability under back-pressure, w_last placement and known response flags.

`default_nettype none

module axi_adapter_chk
  import axi_adapter_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input logic       aw_valid_o,
  input logic       aw_ready_i,
  input addr_t      aw_addr_o,
  input logic [7:0] aw_len_o,
  input logic       w_valid_o,
  input logic       w_ready_i,
  input word_t      w_data_o,
  input logic       w_last_o,
  input logic       b_valid_i,
  input logic       b_ready_o,
  input logic       ar_valid_o,
  input logic       ar_ready_i,
  input addr_t      ar_addr_o,
  input logic       r_valid_i,
  input logic       r_ready_o,
  input word_t      r_data_i,
  input logic       valid_o,
  input logic       critical_word_valid_o
);

  // beats accepted in the current write burst
  logic [7:0] w_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_cnt_q <= '0;
    end else if (w_valid_o && w_ready_i) begin
      w_cnt_q <= w_last_o ? 8'd0 : w_cnt_q + 8'd1;
    end
  end

  // --------------------
  // channel stability
  // --------------------
  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o))
    else $error("AW dropped or changed before ready");
  w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o))
    else $error("W dropped or changed before ready");
  b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_i && !b_ready_o |=> b_valid_i)
    else $error("B dropped before ready");
  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
    else $error("AR dropped or changed before ready");
  r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_i && !r_ready_o |=> r_valid_i && $stable(r_data_i))
    else $error("R dropped or changed before ready");

  w_last_place: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o |-> (w_last_o == (w_cnt_q == aw_len_o)))
    else $error("w_last not on the final beat");

  flags_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(valid_o) && !$isunknown(critical_word_valid_o))
    else $error("response flag is unknown");

endmodule

`default_nettype wire

// File: src/axi_adapter.sv
// Top level of the cache-side AXI adapter. One cache request port with
// req/gnt feeds independent write and read engines; their completions
// share the response port through a round-robin arbiter.

`default_nettype none

module axi_adapter
  import axi_adapter_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // cache request
  input  logic       req_i,
  input  logic       we_i,
  input  req_kind_t  kind_i,
  input  addr_t      addr_i,
  input  line_t      wdata_i,
  input  line_strb_t be_i,
  input  logic [1:0] size_i,
  input  id_t        id_i,
  output logic       gnt_o,
  // cache response
  output logic       valid_o,
  output line_t      rdata_o,
  output id_t        id_o,
  output word_t      critical_word_o,
  output logic       critical_word_valid_o,
  // AXI write
  output logic       aw_valid_o,
  input  logic       aw_ready_i,
  output addr_t      aw_addr_o,
  output logic [7:0] aw_len_o,
  output logic [2:0] aw_size_o,
  output id_t        aw_id_o,
  output logic       w_valid_o,
  input  logic       w_ready_i,
  output word_t      w_data_o,
  output strb_t      w_strb_o,
  output logic       w_last_o,
  input  logic       b_valid_i,
  output logic       b_ready_o,
  input  id_t        b_id_i,
  // AXI read
  output logic       ar_valid_o,
  input  logic       ar_ready_i,
  output addr_t      ar_addr_o,
  output logic [7:0] ar_len_o,
  output logic [2:0] ar_size_o,
  output id_t        ar_id_o,
  input  logic       r_valid_i,
  output logic       r_ready_o,
  input  word_t      r_data_i,
  input  id_t        r_id_i,
  input  logic       r_last_i
);

  logic wr_gnt;
  logic rd_gnt;

  rsp_if wr_rsp ();
  rsp_if rd_rsp ();

  // only one engine answers a request, selected by we_i
  assign gnt_o = wr_gnt | rd_gnt;

  axi_write_engine u_write_engine (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .we_i       (we_i),
    .kind_i     (kind_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .be_i       (be_i),
    .size_i     (size_i),
    .id_i       (id_i),
    .gnt_o      (wr_gnt),
    .aw_valid_o (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .aw_addr_o  (aw_addr_o),
    .aw_len_o   (aw_len_o),
    .aw_size_o  (aw_size_o),
    .aw_id_o    (aw_id_o),
    .w_valid_o  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .w_data_o   (w_data_o),
    .w_strb_o   (w_strb_o),
    .w_last_o   (w_last_o),
    .b_valid_i  (b_valid_i),
    .b_ready_o  (b_ready_o),
    .b_id_i     (b_id_i),
    .rsp        (wr_rsp.engine)
  );

  axi_read_engine u_read_engine (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (req_i),
    .we_i                  (we_i),
    .kind_i                (kind_i),
    .addr_i                (addr_i),
    .size_i                (size_i),
    .id_i                  (id_i),
    .gnt_o                 (rd_gnt),
    .ar_valid_o            (ar_valid_o),
    .ar_ready_i            (ar_ready_i),
    .ar_addr_o             (ar_addr_o),
    .ar_len_o              (ar_len_o),
    .ar_size_o             (ar_size_o),
    .ar_id_o               (ar_id_o),
    .r_valid_i             (r_valid_i),
    .r_ready_o             (r_ready_o),
    .r_data_i              (r_data_i),
    .r_id_i                (r_id_i),
    .r_last_i              (r_last_i),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o),
    .rsp                   (rd_rsp.engine)
  );

  rsp_arbiter u_rsp_arbiter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr      (wr_rsp.arbiter),
    .rd      (rd_rsp.arbiter),
    .valid_o (valid_o),
    .rdata_o (rdata_o),
    .id_o    (id_o)
  );

endmodule

`default_nettype wire

// File: src/rsp_arbiter.sv
// Round-robin merge of the write and read completions onto the single
// cache response port. Outputs follow the granted engine combinationally.

`default_nettype none

module rsp_arbiter
  import axi_adapter_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  rsp_if.arbiter wr,
  rsp_if.arbiter rd,
  output logic   valid_o,
  output line_t  rdata_o,
  output id_t    id_o
);

  // pointer low favours the write engine, high favours the read engine
  logic prio_rd_q;
  logic wr_sel;
  logic rd_sel;

  assign wr_sel = wr.rsp_valid && (!rd.rsp_valid || !prio_rd_q);
  assign rd_sel = rd.rsp_valid && !wr_sel;

  assign wr.rsp_grant = wr_sel;
  assign rd.rsp_grant = rd_sel;

  assign valid_o = wr_sel || rd_sel;
  assign rdata_o = rd_sel ? rd.rsp_data : wr.rsp_data;
  assign id_o    = rd_sel ? rd.rsp_id : wr.rsp_id;

  // move past whichever engine was just served
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_rd_q <= 1'b0;
    end else if (wr_sel) begin
      prio_rd_q <= 1'b1;
    end else if (rd_sel) begin
      prio_rd_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/axi_read_engine.sv
// Read side of the adapter: issues AR and collects R beats into a line.
// Line reads go out at the line-aligned address; the beat whose index
// matches the requested word offset is flagged as the critical word.
// The finished line is returned as a completion on the rsp interface.

`default_nettype none

module axi_read_engine
  import axi_adapter_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       we_i,
  input  req_kind_t  kind_i,
  input  addr_t      addr_i,
  input  logic [1:0] size_i,
  input  id_t        id_i,
  output logic       gnt_o,
  output logic       ar_valid_o,
  input  logic       ar_ready_i,
  output addr_t      ar_addr_o,
  output logic [7:0] ar_len_o,
  output logic [2:0] ar_size_o,
  output id_t        ar_id_o,
  input  logic       r_valid_i,
  output logic       r_ready_o,
  input  word_t      r_data_i,
  input  id_t        r_id_i,
  input  logic       r_last_i,
  output word_t      critical_word_o,
  output logic       critical_word_valid_o,
  rsp_if.engine      rsp
);

  typedef enum logic [1:0] {R_IDLE, R_DATA, R_DONE} rd_state_e;

  rd_state_e state_q, state_d;
  req_kind_t kind_q;
  beat_cnt_t offset_q;
  beat_cnt_t beat_q;
  line_t     line_q;
  id_t       id_q;

  logic      r_hs;
  beat_cnt_t slot;

  // --------------------
  // AR channel
  // --------------------
  assign ar_valid_o = (state_q == R_IDLE) && req_i && !we_i;
  assign ar_addr_o  = (kind_i == LINE_REQ) ?
                      {addr_i[ADDR_WIDTH-1:LINE_OFFSET], {LINE_OFFSET{1'b0}}} : addr_i;
  assign ar_len_o   = (kind_i == LINE_REQ) ? 8'(BURST_LEN) : 8'd0;
  assign ar_size_o  = {1'b0, size_i};
  assign ar_id_o    = id_i;
  assign gnt_o      = ar_valid_o && ar_ready_i;

  // --------------------
  // R channel
  // --------------------
  assign r_ready_o = (state_q == R_DATA);
  assign r_hs      = r_ready_o && r_valid_i;

  // single reads always land in word 0
  assign slot = (kind_q == LINE_REQ) ? beat_q : '0;

  assign critical_word_o       = r_data_i;
  assign critical_word_valid_o = r_hs && (kind_q == LINE_REQ) && (beat_q == offset_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      R_IDLE: begin
        if (gnt_o) begin
          state_d = R_DATA;
        end
      end
      R_DATA: begin
        if (r_hs && r_last_i) begin
          state_d = R_DONE;
        end
      end
      R_DONE: begin
        if (rsp.rsp_grant) begin
          state_d = R_IDLE;
        end
      end
      default: state_d = R_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= R_IDLE;
      kind_q   <= SINGLE_REQ;
      offset_q <= '0;
      beat_q   <= '0;
    end else begin
      state_q <= state_d;
      if (gnt_o) begin
        kind_q   <= kind_i;
        offset_q <= addr_i[LINE_OFFSET-1 -: $bits(beat_cnt_t)];
        beat_q   <= '0;
      end else if (r_hs) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // line buffer starts clean so unused words of a single read read as zero
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      line_q <= '0;
    end else if (r_hs) begin
      line_q[slot] <= r_data_i;
      if (r_last_i) begin
        id_q <= r_id_i;
      end
    end
  end

  assign rsp.rsp_valid = (state_q == R_DONE);
  assign rsp.rsp_data  = line_q;
  assign rsp.rsp_id    = id_q;

endmodule

`default_nettype wire

// File: src/axi_write_engine.sv
// Write side of the adapter: drives AW, W and B for single-word and
// full-line writes. Request fields are held by the cache until gnt_o,
// so beat data is taken straight from wdata_i and be_i.
// The B response is returned as a completion on the rsp interface.

`default_nettype none

module axi_write_engine
  import axi_adapter_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       we_i,
  input  req_kind_t  kind_i,
  input  addr_t      addr_i,
  input  line_t      wdata_i,
  input  line_strb_t be_i,
  input  logic [1:0] size_i,
  input  id_t        id_i,
  output logic       gnt_o,
  output logic       aw_valid_o,
  input  logic       aw_ready_i,
  output addr_t      aw_addr_o,
  output logic [7:0] aw_len_o,
  output logic [2:0] aw_size_o,
  output id_t        aw_id_o,
  output logic       w_valid_o,
  input  logic       w_ready_i,
  output word_t      w_data_o,
  output strb_t      w_strb_o,
  output logic       w_last_o,
  input  logic       b_valid_i,
  output logic       b_ready_o,
  input  id_t        b_id_i,
  rsp_if.engine      rsp
);

  typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP, W_DONE} wr_state_e;

  wr_state_e state_q, state_d;
  logic      aw_done_q, aw_done_d;
  logic      w_done_q, w_done_d;
  beat_cnt_t beat_q, beat_d;
  id_t       id_q;

  logic      active;
  logic      aw_pend;
  logic      w_pend;
  beat_cnt_t beat;
  logic      last_beat;
  logic      aw_hs;
  logic      w_hs;
  logic      aw_fin;
  logic      w_fin;

  // a new request is picked up straight from idle
  assign active    = (state_q == W_DATA) || (state_q == W_IDLE && req_i && we_i);
  assign aw_pend   = (state_q == W_IDLE) || !aw_done_q;
  assign w_pend    = (state_q == W_IDLE) || !w_done_q;
  assign beat      = (state_q == W_IDLE) ? '0 : beat_q;
  assign last_beat = (kind_i == SINGLE_REQ) || (beat == beat_cnt_t'(BURST_LEN));

  // --------------------
  // AXI channels
  // --------------------
  assign aw_valid_o = active && aw_pend;
  assign aw_addr_o  = addr_i;
  assign aw_len_o   = (kind_i == LINE_REQ) ? 8'(BURST_LEN) : 8'd0;
  assign aw_size_o  = {1'b0, size_i};
  assign aw_id_o    = id_i;

  assign w_valid_o = active && w_pend;
  assign w_data_o  = wdata_i[beat];
  assign w_strb_o  = be_i[beat];
  assign w_last_o  = last_beat;

  assign b_ready_o = (state_q == W_RESP);

  assign aw_hs  = aw_valid_o && aw_ready_i;
  assign w_hs   = w_valid_o && w_ready_i;
  assign aw_fin = !aw_pend || aw_hs;
  assign w_fin  = !w_pend || (w_hs && last_beat);

  // grant with whichever of AW and the final W finishes last
  assign gnt_o = active && aw_fin && w_fin;

  always_comb begin
    state_d   = state_q;
    aw_done_d = aw_done_q;
    w_done_d  = w_done_q;
    beat_d    = beat;
    if (active) begin
      if (gnt_o) begin
        state_d = W_RESP;
      end else begin
        state_d   = W_DATA;
        aw_done_d = aw_fin;
        w_done_d  = w_fin;
        if (w_hs && !last_beat) begin
          beat_d = beat + 1'b1;
        end
      end
    end else if (state_q == W_RESP && b_valid_i) begin
      state_d = W_DONE;
    end else if (state_q == W_DONE && rsp.rsp_grant) begin
      state_d = W_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= W_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      beat_q    <= '0;
    end else begin
      state_q   <= state_d;
      aw_done_q <= aw_done_d;
      w_done_q  <= w_done_d;
      beat_q    <= beat_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_ready_o && b_valid_i) begin
      id_q <= b_id_i;
    end
  end

  // --------------------
  // completion
  // --------------------
  assign rsp.rsp_valid = (state_q == W_DONE);
  assign rsp.rsp_data  = '0;
  assign rsp.rsp_id    = id_q;

endmodule

`default_nettype wire

// File: src/rsp_if.sv
// Completion path from one engine to the response arbiter.
// The engine holds valid, data and id until a cycle with grant high.

`default_nettype none

interface rsp_if
  import axi_adapter_pkg::*;
();

  logic  rsp_valid;
  line_t rsp_data;
  id_t   rsp_id;
  logic  rsp_grant;

  modport engine (
    output rsp_valid, rsp_data, rsp_id,
    input  rsp_grant
  );

  modport arbiter (
    input  rsp_valid, rsp_data, rsp_id,
    output rsp_grant
  );

endinterface

`default_nettype wire

// File: src/axi_adapter_pkg.sv
// Shared widths and types of the cache-side AXI adapter.
// Every RTL block imports this package in its module header.
// A line is four 32-bit words; beats travel one word at a time.

`default_nettype none

package axi_adapter_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int WORD_WIDTH     = 32;
  localparam int WORDS_PER_LINE = 4;
  // AXI len field of a line burst, beats minus one
  localparam int BURST_LEN      = WORDS_PER_LINE - 1;
  // byte-offset bits inside one line
  localparam int LINE_OFFSET    = 4;
  localparam int ADDR_WIDTH     = 32;
  localparam int ID_WIDTH       = 4;

  // --------------------
  // types
  // --------------------
  typedef logic [WORD_WIDTH-1:0]   word_t;
  typedef logic [WORD_WIDTH/8-1:0] strb_t;

  typedef logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0]   line_t;
  typedef logic [WORDS_PER_LINE-1:0][WORD_WIDTH/8-1:0] line_strb_t;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [ID_WIDTH-1:0]   id_t;

  // index of a beat inside a line
  typedef logic [$clog2(WORDS_PER_LINE)-1:0] beat_cnt_t;

  typedef enum logic {
    SINGLE_REQ = 1'b0,
    LINE_REQ   = 1'b1
  } req_kind_t;

endpackage

`default_nettype wire
